// ==== rtl/spi_router_defines.svh ====
`ifndef SPI_ROUTER_DEFINES_SVH
`define SPI_ROUTER_DEFINES_SVH

////////////////////
// spi framing
////////////////////

// sck periods in one register bank frame
`define SPI_FRAME_BITS 16

// address byte holds the read-only flag and the register select
`define SPI_ADDR_BITS 8

////////////////////
// board side
////////////////////

// routable peripheral chip selects
`define SPI_PORTS 8

// flops per pin synchronizer, keep at 2 or more
`define SPI_SYNC_STAGES 2

`endif

// ==== rtl/spi_frame_pkg.sv ====
`default_nettype none
`include "spi_router_defines.svh"

package spi_frame_pkg;

  // value byte is whatever is left after the address
  localparam int DATA_BITS = `SPI_FRAME_BITS - `SPI_ADDR_BITS;

  // high byte of a frame
  // read_only set means readback only and no commit
  typedef struct packed {
    logic                      read_only;
    logic [`SPI_ADDR_BITS-2:0] reg_sel;
  } frame_addr_t;

  // low byte of a frame
  typedef logic [DATA_BITS-1:0] frame_data_t;

  // whole frame in shift order, address first on the wire
  typedef struct packed {
    frame_addr_t addr;
    frame_data_t data;
  } spi_frame_t;

endpackage

`default_nettype wire

// ==== rtl/board_reg_pkg.sv ====
`default_nettype none
`include "spi_router_defines.svh"

package board_reg_pkg;

  ////////////////////
  // register map
  ////////////////////

  // matches the reg_sel field of the address byte
  typedef enum logic [`SPI_ADDR_BITS-2:0] {
    REG_LED = 7,
    REG_MUX = 8,
    REG_DAC = 9
  } reg_sel_e;

  ////////////////////
  // register layouts
  ////////////////////

  // dac control lines, msb first as in the schematic
  typedef struct packed {
    logic uni_bip_b;
    logic uni_bip_a;
    logic dac_rst;
    logic ldac;
  } dac_ctrl_t;

  // one bit per routed peripheral
  typedef logic [`SPI_PORTS-1:0] port_mask_t;

endpackage

`default_nettype wire

// ==== rtl/spi_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "spi_router_defines.svh"

module spi_frontend (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  sck,
  input  wire  cs_n,
  input  wire  mosi,
  input  wire  special_n,
  output logic sck_rise,
  output logic sck_fall,
  output logic frame_start,
  output logic frame_end,
  output logic sel,
  output logic mosi_s
);

  localparam int LAST = `SPI_SYNC_STAGES - 1;

  ////////////////////
  // pin synchronizers
  ////////////////////

  // one chain per pin, new sample enters at bit 0
  logic [LAST:0] sck_sync;
  logic [LAST:0] cs_sync;
  logic [LAST:0] mosi_sync;
  logic [LAST:0] spec_sync;
  logic          sck_q;
  logic          sel_now;

  // idle bus levels so reset looks like no frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
      spec_sync <= '1;
    end
    else
    begin
      sck_sync  <= {sck_sync[LAST-1:0], sck};
      cs_sync   <= {cs_sync[LAST-1:0], cs_n};
      mosi_sync <= {mosi_sync[LAST-1:0], mosi};
      spec_sync <= {spec_sync[LAST-1:0], special_n};
    end
  end

  // bank only listens while both selects are low
  assign sel_now = ~cs_sync[LAST] & ~spec_sync[LAST];

  ////////////////////
  // edge detect
  ////////////////////

  // pulses registered so they line up with sel and mosi_s
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sck_q       <= 1'b0;
      sel         <= 1'b0;
      mosi_s      <= 1'b0;
      sck_rise    <= 1'b0;
      sck_fall    <= 1'b0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
    end
    else
    begin
      sck_q       <= sck_sync[LAST];
      sel         <= sel_now;
      mosi_s      <= mosi_sync[LAST];
      sck_rise    <= sck_sync[LAST] & ~sck_q;
      sck_fall    <= ~sck_sync[LAST] & sck_q;
      frame_start <= sel_now & ~sel;
      frame_end   <= ~sel_now & sel;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/spi_reg_bank.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "spi_router_defines.svh"

module spi_reg_bank (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        sck_rise,
  input  wire                        sck_fall,
  input  wire                        frame_start,
  input  wire                        frame_end,
  input  wire                        sel,
  input  wire                        mosi_s,
  output logic                       sdo,
  output board_reg_pkg::port_mask_t  reg_mux,
  output spi_frame_pkg::frame_data_t reg_led,
  output board_reg_pkg::dac_ctrl_t   reg_dac
);

  import spi_frame_pkg::*;
  import board_reg_pkg::*;

  // one spare bit so an overlong frame can saturate above the frame length
  localparam int               CNT_W     = $clog2(`SPI_FRAME_BITS) + 1;
  localparam logic [CNT_W-1:0] CNT_MAX   = '1;
  localparam logic [CNT_W-1:0] CNT_FRAME = CNT_W'(`SPI_FRAME_BITS);
  localparam logic [CNT_W-1:0] CNT_ADDR  = CNT_W'(`SPI_ADDR_BITS);

  logic [CNT_W-1:0] bit_cnt;
  spi_frame_t       shift_r;
  frame_data_t      rb_r;
  frame_addr_t      rb_addr;
  frame_data_t      rb_value;
  logic             commit_ok;

  ////////////////////
  // frame capture
  ////////////////////

  // saturating count of sck rising edges in this frame
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (frame_start)
      bit_cnt <= '0;
    else if (sck_rise && sel && bit_cnt != CNT_MAX)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // msb first with the new bit into lsb
  always_ff @(posedge clk)
  begin
    if (frame_start)
      shift_r <= '0;
    else if (sck_rise && sel)
      shift_r <= {shift_r[`SPI_FRAME_BITS-2:0], mosi_s};
  end

  ////////////////////
  // readback
  ////////////////////

  // after eight bits the address byte sits in the low half
  assign rb_addr = shift_r.data;

  // unknown selects read back as zero
  always_comb
  begin
    case (rb_addr.reg_sel)
      REG_LED: rb_value = reg_led;
      REG_MUX: rb_value = frame_data_t'(reg_mux);
      REG_DAC: rb_value = frame_data_t'(reg_dac);
      default: rb_value = '0;
    endcase
  end

  // zeros during the address byte
  // load on the fall after the 8th rise and shift one bit per later fall
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rb_r <= '0;
    else if (frame_start)
      rb_r <= '0;
    else if (sck_fall && sel)
    begin
      if (bit_cnt == CNT_ADDR)
        rb_r <= rb_value;
      else
        rb_r <= {rb_r[DATA_BITS-2:0], 1'b0};
    end
  end

  assign sdo = rb_r[DATA_BITS-1];

  ////////////////////
  // register file
  ////////////////////

  // exact length and not a read-only frame
  assign commit_ok = frame_end && (bit_cnt == CNT_FRAME) && !shift_r.addr.read_only;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      reg_mux <= '0;
      reg_led <= '0;
      reg_dac <= '0;
    end
    else if (commit_ok)
    begin
      case (shift_r.addr.reg_sel)
        REG_LED: reg_led <= shift_r.data;
        REG_MUX: reg_mux <= port_mask_t'(shift_r.data);
        // dac keeps only its four control bits
        REG_DAC: reg_dac <= shift_r.data[$bits(dac_ctrl_t)-1:0];
        // unknown select writes nothing
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/spi_route.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "spi_router_defines.svh"

module spi_route (
  input  wire                       cs_n,
  input  wire                       special_n,
  input  wire                       mosi,
  input  wire                       sck,
  input  wire board_reg_pkg::port_mask_t reg_mux,
  input  wire                       sdo,
  input  wire board_reg_pkg::port_mask_t periph_miso,
  output wire board_reg_pkg::port_mask_t periph_cs_n,
  output wire                       periph_sck,
  output wire                       periph_mosi,
  output wire                       miso
);

  import board_reg_pkg::*;

  ////////////////////
  // chip selects
  ////////////////////

  // special low means the bank owns the bus
  // every peripheral stays deselected so none sees the frame
  assign periph_cs_n = special_n ? (~reg_mux | {`SPI_PORTS{cs_n}}) : '1;

  ////////////////////
  // clock and data out
  ////////////////////

  // shared by all peripherals, gating is by chip select only
  assign periph_sck  = sck;
  assign periph_mosi = mosi;

  ////////////////////
  // miso return
  ////////////////////

  // OR of the enabled lines
  // no tri-state on the board so masked lines must not leak through
  assign miso = special_n ? |(reg_mux & periph_miso) : sdo;

endmodule

`default_nettype wire

// ==== rtl/spi_router_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_router_top (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            sck,
  input  wire                            cs_n,
  input  wire                            mosi,
  input  wire                            special_n,
  input  wire board_reg_pkg::port_mask_t periph_miso,
  output wire                            miso,
  output wire board_reg_pkg::port_mask_t periph_cs_n,
  output wire                            periph_sck,
  output wire                            periph_mosi,
  output wire [1:0]                      led,
  output wire                            dac_ldac,
  output wire                            dac_rst,
  output wire                            dac_uni_bip_a,
  output wire                            dac_uni_bip_b
);

  import spi_frame_pkg::*;
  import board_reg_pkg::*;

  // frontend pulses and levels in the clk domain
  logic sck_rise;
  logic sck_fall;
  logic frame_start;
  logic frame_end;
  logic sel;
  logic mosi_s;

  // bank outputs
  logic        sdo;
  port_mask_t  reg_mux;
  frame_data_t reg_led;
  dac_ctrl_t   reg_dac;

  ////////////////////
  // register bank path
  ////////////////////

  spi_frontend i_frontend (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .special_n   (special_n),
    .sck_rise    (sck_rise),
    .sck_fall    (sck_fall),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .sel         (sel),
    .mosi_s      (mosi_s)
  );

  spi_reg_bank i_reg_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .sck_rise    (sck_rise),
    .sck_fall    (sck_fall),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .sel         (sel),
    .mosi_s      (mosi_s),
    .sdo         (sdo),
    .reg_mux     (reg_mux),
    .reg_led     (reg_led),
    .reg_dac     (reg_dac)
  );

  ////////////////////
  // routing, no clock
  ////////////////////

  spi_route i_route (
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mosi        (mosi),
    .sck         (sck),
    .reg_mux     (reg_mux),
    .sdo         (sdo),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .periph_sck  (periph_sck),
    .periph_mosi (periph_mosi),
    .miso        (miso)
  );

  // only two leds fitted
  assign led = reg_led[1:0];

  // dac control pins straight from the register fields
  assign dac_ldac      = reg_dac.ldac;
  assign dac_rst       = reg_dac.dac_rst;
  assign dac_uni_bip_a = reg_dac.uni_bip_a;
  assign dac_uni_bip_b = reg_dac.uni_bip_b;

endmodule

`default_nettype wire

// ==== testbench/spi_router_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module spi_router_properties (
  input wire                             clk,
  input wire                             rst_n,
  input wire                             special_n,
  input wire board_reg_pkg::port_mask_t  reg_mux,
  input wire board_reg_pkg::port_mask_t  periph_cs_n,
  input wire spi_frame_pkg::frame_data_t reg_led,
  input wire board_reg_pkg::dac_ctrl_t   reg_dac
);

  import board_reg_pkg::*;

  localparam port_mask_t ALL_DESEL = '1;

  ////////////////////
  // routing
  ////////////////////

  // bank owns the bus, every peripheral deselected
  a_bank_isolates: assert property (@(posedge clk) disable iff (!rst_n)
    !special_n |-> (periph_cs_n == ALL_DESEL))
    else $error("peripheral chip select active while the bank is addressed");

  // masked port never selected
  a_mask_deselects: assert property (@(posedge clk) disable iff (!rst_n)
    (periph_cs_n | reg_mux) == ALL_DESEL)
    else $error("chip select active on a port that is off in the mux register");

  ////////////////////
  // reset state
  ////////////////////

  // second reset cycle onward, all registers cleared
  a_reset_clears: assert property (@(posedge clk)
    (!rst_n && !$past(rst_n)) |-> (reg_mux == '0 && reg_led == '0 && reg_dac == '0))
    else $error("register outputs not cleared during reset");

endmodule

bind spi_router_top spi_router_properties i_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .special_n   (special_n),
  .reg_mux     (reg_mux),
  .periph_cs_n (periph_cs_n),
  .reg_led     (reg_led),
  .reg_dac     (reg_dac)
);

`default_nettype wire

// ==== testbench/tb_spi_router.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "spi_router_defines.svh"

module tb_spi_router;

  import board_reg_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int SCK_HALF   = 8;
  localparam int GAP_CLKS   = 6;
  localparam int N_WR       = 24;
  localparam int N_PIN      = 16;
  localparam int N_REJ      = 24;
  localparam int N_ROUTE    = 8;
  localparam int N_VEC      = 16;
  // a reject round is at most five frames
  // any frame fits in 40 sck half periods
  localparam int     NUM_FRAMES = 3 + 2 * N_WR + N_PIN + 5 * N_REJ + N_ROUTE;
  localparam longint TIMEOUT_NS =
    longint'(NUM_FRAMES) * 40 * SCK_HALF * CLK_PERIOD + 100_000;

  logic       clk;
  logic       rst_n;
  logic       sck;
  logic       cs_n;
  logic       mosi;
  logic       special_n;
  port_mask_t periph_miso;
  wire        miso;
  wire port_mask_t periph_cs_n;
  wire        periph_sck;
  wire        periph_mosi;
  wire [1:0]  led;
  wire        dac_ldac;
  wire        dac_rst;
  wire        dac_uni_bip_a;
  wire        dac_uni_bip_b;

  // reference model of the register bank
  logic [7:0] m_led;
  port_mask_t m_mux;
  logic [3:0] m_dac;

  integer seed;
  int     error_count;
  int     check_count;
  int     test_count;

  spi_router_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .sck           (sck),
    .cs_n          (cs_n),
    .mosi          (mosi),
    .special_n     (special_n),
    .periph_miso   (periph_miso),
    .miso          (miso),
    .periph_cs_n   (periph_cs_n),
    .periph_sck    (periph_sck),
    .periph_mosi   (periph_mosi),
    .led           (led),
    .dac_ldac      (dac_ldac),
    .dac_rst       (dac_rst),
    .dac_uni_bip_a (dac_uni_bip_a),
    .dac_uni_bip_b (dac_uni_bip_b)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // helpers
  ////////////////////

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp)
    begin
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, error_count - errs_before);
  endtask

  // one of the three known selects
  function automatic logic [6:0] pick_reg(input logic [31:0] r);
    case (r % 3)
      0:       return REG_LED;
      1:       return REG_MUX;
      default: return REG_DAC;
    endcase
  endfunction

  // write rule needs exact length, a clear read-only bit and a known select
  task automatic model_apply(input logic [15:0] frame, input int nbits);
    if (nbits == `SPI_FRAME_BITS && !frame[15])
    begin
      case (frame[14:8])
        REG_LED: m_led = frame[7:0];
        REG_MUX: m_mux = frame[7:0];
        REG_DAC: m_dac = frame[3:0];
        default: ;
      endcase
    end
  endtask

  function automatic logic [7:0] expected_read(input logic [6:0] reg_sel);
    case (reg_sel)
      REG_LED: return m_led;
      REG_MUX: return m_mux;
      REG_DAC: return {4'b0000, m_dac};
      default: return 8'h00;
    endcase
  endfunction

  ////////////////////
  // spi master
  ////////////////////

  // mode 0, msb first, bank selected for the whole frame
  task automatic spi_transfer(input logic [31:0] bits, input int nbits, output logic [31:0] rx);
    int k;
    rx = '0;
    @(negedge clk);
    sck       = 1'b0;
    cs_n      = 1'b0;
    special_n = 1'b0;
    wait_clks(SCK_HALF);
    for (k = nbits - 1; k >= 0; k--)
    begin
      mosi = bits[k];
      wait_clks(SCK_HALF);
      // last sample point before sck rises
      rx  = {rx[30:0], miso};
      sck = 1'b1;
      wait_clks(SCK_HALF);
      sck = 1'b0;
    end
    wait_clks(SCK_HALF);
    cs_n      = 1'b1;
    special_n = 1'b1;
    mosi      = 1'b0;
    // commit lands within 4 clks
    wait_clks(GAP_CLKS);
  endtask

  task automatic write_reg(input logic [6:0] reg_sel, input logic [7:0] data);
    logic [31:0] rx;
    spi_transfer({16'h0000, 1'b0, reg_sel, data}, `SPI_FRAME_BITS, rx);
    model_apply({1'b0, reg_sel, data}, `SPI_FRAME_BITS);
  endtask

  task automatic check_read(input logic [6:0] reg_sel);
    logic [31:0] rx;
    spi_transfer({16'h0000, 1'b1, reg_sel, 8'h00}, `SPI_FRAME_BITS, rx);
    // bank drives zeros while the address shifts in
    check_value("miso address byte", 32'h0, 32'(rx[15:8]));
    check_value($sformatf("readback reg %0d", reg_sel), 32'(expected_read(reg_sel)),
                32'(rx[7:0]));
  endtask

  task automatic check_regs();
    check_read(REG_LED);
    check_read(REG_MUX);
    check_read(REG_DAC);
  endtask

  // bus idle here so no peripheral is selected
  task automatic check_pins();
    check_value("led", 32'(m_led[1:0]), 32'(led));
    check_value("dac_ldac", 32'(m_dac[0]), 32'(dac_ldac));
    check_value("dac_rst", 32'(m_dac[1]), 32'(dac_rst));
    check_value("dac_uni_bip_a", 32'(m_dac[2]), 32'(dac_uni_bip_a));
    check_value("dac_uni_bip_b", 32'(m_dac[3]), 32'(dac_uni_bip_b));
    check_value("periph_cs_n", 32'({`SPI_PORTS{1'b1}}), 32'(periph_cs_n));
  endtask

  // routing rule applied bit by bit
  task automatic check_route();
    port_mask_t exp_cs;
    logic       exp_miso;
    int         p;
    exp_miso = 1'b0;
    for (p = 0; p < `SPI_PORTS; p++)
    begin
      exp_cs[p] = (special_n && m_mux[p]) ? cs_n : 1'b1;
      exp_miso  = exp_miso | (m_mux[p] & periph_miso[p]);
    end
    check_value("periph_cs_n", 32'(exp_cs), 32'(periph_cs_n));
    check_value("miso", 32'(exp_miso), 32'(miso));
    check_value("periph_sck", 32'(sck), 32'(periph_sck));
    check_value("periph_mosi", 32'(mosi), 32'(periph_mosi));
  endtask

  ////////////////////
  // watchdog
  ////////////////////

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

  ////////////////////
  // tests
  ////////////////////

  initial
  begin
    logic [31:0] r;
    logic [31:0] rx;
    logic [6:0]  reg_sel;
    int          len;
    int          kind;
    int          errs;
    int          i;
    int          v;
    seed        = 32'ha220;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    m_led       = '0;
    m_mux       = '0;
    m_dac       = '0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    sck         = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    special_n   = 1'b1;
    periph_miso = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_clks(4);

    // everything cleared, nothing routed
    errs = error_count;
    check_pins();
    check_regs();
    finish_test("reset_state", errs);

    errs = error_count;
    for (i = 0; i < N_WR; i++)
    begin
      r       = $random(seed);
      reg_sel = pick_reg(r);
      r       = $random(seed);
      write_reg(reg_sel, r[7:0]);
      check_pins();
      check_read(reg_sel);
    end
    finish_test("write_readback", errs);

    // led and dac only with pins checked after the commit gap
    errs = error_count;
    for (i = 0; i < N_PIN; i++)
    begin
      r = $random(seed);
      write_reg((i % 2 == 0) ? REG_LED : REG_DAC, r[7:0]);
      check_pins();
    end
    finish_test("pin_outputs", errs);

    errs = error_count;
    for (i = 0; i < N_REJ; i++)
    begin
      kind = $unsigned($random(seed)) % 3;
      r    = $random(seed);
      if (kind == 0)
      begin
        // short or overlong frame
        len = 1 + ($unsigned($random(seed)) % 18);
        if (len == `SPI_FRAME_BITS)
          len = `SPI_FRAME_BITS + 1;
        spi_transfer(r, len, rx);
        model_apply(r[15:0], len);
      end
      else if (kind == 1)
      begin
        reg_sel = pick_reg($random(seed));
        spi_transfer({16'h0000, 1'b1, reg_sel, r[7:0]}, `SPI_FRAME_BITS, rx);
        model_apply({1'b1, reg_sel, r[7:0]}, `SPI_FRAME_BITS);
        // read-only frame still shifts the register out
        check_value("read-only readback", 32'(expected_read(reg_sel)), 32'(rx[7:0]));
      end
      else
      begin
        reg_sel = r[14:8];
        if (reg_sel >= 7'd7 && reg_sel <= 7'd9)
          reg_sel = reg_sel + 7'd16;
        write_reg(reg_sel, r[7:0]);
        check_read(reg_sel);
      end
      check_pins();
      check_regs();
    end
    finish_test("rejected_frames", errs);

    errs = error_count;
    for (i = 0; i < N_ROUTE; i++)
    begin
      r = $random(seed);
      write_reg(REG_MUX, r[7:0]);
      for (v = 0; v < N_VEC; v++)
      begin
        @(negedge clk);
        r           = $random(seed);
        cs_n        = r[0];
        sck         = r[1];
        mosi        = r[2];
        periph_miso = r[15:8];
        // one full clk later the combinational paths have settled
        @(negedge clk);
        check_route();
      end
      cs_n        = 1'b1;
      sck         = 1'b0;
      mosi        = 1'b0;
      periph_miso = '0;
    end
    finish_test("routing", errs);

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== spi_router.f ====
+incdir+rtl
rtl/spi_frame_pkg.sv
rtl/board_reg_pkg.sv
rtl/spi_frontend.sv
rtl/spi_reg_bank.sv
rtl/spi_route.sv
rtl/spi_router_top.sv
testbench/spi_router_properties.sv
testbench/tb_spi_router.sv

// ==== Makefile ====
TOP = tb_spi_router

.PHONY: all lint clean

# build, run, and pass only when the pass message shows up
all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /^Regression passed$$/ { ok = 1 } END { exit !ok }'

obj_dir/V$(TOP): spi_router.f rtl/*.sv rtl/*.svh testbench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f spi_router.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f spi_router.f

clean:
	rm -rf obj_dir
